// ==== rvcpu.f ====
isa_pkg.sv
core_pkg.sv
if_stage.sv
id_stage.sv
regfile.sv
exe_stage.sv
rvcpu.sv
tb_clock_gen.sv
tb_rvcpu.sv

// ==== Bender.yml ====
package:
  name: rvcpu

sources:
  - isa_pkg.sv
  - core_pkg.sv
  - if_stage.sv
  - id_stage.sv
  - regfile.sv
  - exe_stage.sv
  - rvcpu.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_rvcpu.sv

// ==== tb_rvcpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rvcpu
  import isa_pkg::*;
();

  localparam int          XLEN       = 64;
  localparam logic [63:0] RESET_PC   = 64'h8000_0000;
  localparam int          IMEM_DEPTH = 64;
  localparam int          TIMEOUT    = 200;

  logic        clk, por_rst, test_rst, rst;
  logic [63:0] inst_addr, imem_idx;
  logic        inst_ena;
  inst_t       inst;
  logic [63:0] regs_o [32];
  inst_t       imem [IMEM_DEPTH];
  logic [63:0] model [32];
  int          prog_len, test_errors, tests_run, tests_failed;

  tb_clock_gen i_clock_gen (.clk, .rst(por_rst));

  assign rst = por_rst | test_rst;

  rvcpu #(.XLEN(XLEN), .RESET_PC(RESET_PC)) i_rvcpu (
    .clk, .rst, .inst_addr, .inst_ena, .inst, .regs_o
  );

  // Instruction memory reads NOP outside the loaded program
  always_comb begin
    imem_idx = (inst_addr - RESET_PC) >> 2;
    inst     = (imem_idx < 64'(prog_len)) ? imem[imem_idx[5:0]] : NOP;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encoders and reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic inst_t i_type(funct3_e f3, int rd, int rs1, int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], OP_IMM};
  endfunction

  function automatic inst_t r_type(funct3_e f3, int alt, int rd, int rs1, int rs2);
    return {1'b0, alt[0], 5'b0, rs2[4:0], rs1[4:0], f3, rd[4:0], OP};
  endfunction

  function automatic inst_t u_type(int rd, int imm);
    return {imm[19:0], rd[4:0], LUI};
  endfunction

  function automatic inst_t j_type(int rd, int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], JAL};
  endfunction

  function automatic void emit(inst_t w);
    imem[prog_len] = w;
    prog_len++;
  endfunction

  task automatic run_model(input logic [63:0] end_addr);
    logic [63:0] pc, a, b, res;
    inst_t       w;
    int          steps;
    for (int i = 0; i < 32; i++) model[i] = '0;
    pc    = RESET_PC;
    steps = 0;
    while (pc != end_addr && steps < TIMEOUT) begin
      w   = imem[(pc - RESET_PC) >> 2];
      a   = model[w[19:15]];
      b   = (w[6:0] == OP) ? model[w[24:20]] : 64'($signed(w[31:20]));
      res = '0;
      case (w[14:12])
        3'd0: res = (w[6:0] == OP && w[30]) ? a - b : a + b;
        3'd1: res = a << b[5:0];  // 6-bit shift amount
        3'd2: res = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        3'd3: res = (a < b) ? 64'd1 : 64'd0;
        3'd4: res = a ^ b;
        3'd5: begin
          if (w[30]) res = $signed(a) >>> b[5:0];
          else res = a >> b[5:0];
        end
        3'd6: res = a | b;
        default: res = a & b;
      endcase
      if (w[6:0] == LUI) res = 64'($signed({w[31:12], 12'h000}));
      if (w[6:0] == JAL) res = pc + 64'd4;
      if (w[11:7] != 5'd0 && (w[6:0] == OP_IMM || w[6:0] == OP ||
                              w[6:0] == LUI || w[6:0] == JAL)) begin
        model[w[11:7]] = res;
      end
      if (w[6:0] == JAL) pc = pc + 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      else pc = pc + 64'd4;
      steps++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Run and check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic pulse_reset();
    @(posedge clk);
    test_rst <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    if (inst_ena !== 1'b0) begin
      $display("FAILED at %0t: inst_ena high during reset", $time);
      test_errors++;
    end
    for (int i = 0; i < 32; i++) begin
      if (regs_o[i] !== '0) begin
        $display("FAILED at %0t: x%0d not zero during reset, got %h", $time, i, regs_o[i]);
        test_errors++;
      end
    end
    repeat (3) @(posedge clk);
    test_rst <= 1'b0;
    @(negedge clk);
    if (inst_addr !== RESET_PC) begin
      $display("FAILED at %0t: first fetch at %h, expected %h", $time, inst_addr, RESET_PC);
      test_errors++;
    end
    if (inst_ena !== 1'b1) begin
      $display("FAILED at %0t: inst_ena low after reset", $time);
      test_errors++;
    end
  endtask

  task automatic execute_and_check(input string name);
    logic [63:0] end_addr;
    int          cycles;
    end_addr    = RESET_PC + 64'(prog_len) * 64'd4;
    cycles      = 0;
    test_errors = 0;
    pulse_reset();
    while (inst_addr !== end_addr && cycles < TIMEOUT) begin
      if (regs_o[0] !== '0) begin  // x0 must never show a write
        $display("FAILED at %0t: x0 shows %h", $time, regs_o[0]);
        test_errors++;
      end
      @(negedge clk);
      cycles++;
    end
    tests_run++;
    if (inst_addr !== end_addr) begin
      $display("Test %s hung: fetch never reached the end of the program", name);
      test_errors++;
    end else begin
      run_model(end_addr);
      for (int i = 0; i < 32; i++) begin
        if (regs_o[i] !== model[i]) begin
          $display("FAILED at %0t: x%0d expected %h, got %h", $time, i, model[i], regs_o[i]);
          test_errors++;
        end
      end
    end
    if (test_errors != 0) tests_failed++;
    $display("%s: %0d errors", name, test_errors);
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Directed tests
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic reset_state();
    prog_len = 0;
    emit(i_type(ADD_SUB, 1, 0, 42));
    execute_and_check("reset_state");
  endtask

  task automatic imm_arith();
    prog_len = 0;
    emit(i_type(ADD_SUB, 1, 0, -5));
    emit(i_type(ADD_SUB, 2, 0, 100));
    emit(i_type(SLT, 3, 1, -4));
    emit(i_type(SLTU, 4, 1, 5));     // -5 is huge unsigned
    emit(i_type(SLTU, 5, 2, -1));
    emit(i_type(XOR, 6, 1, -1));
    emit(i_type(OR, 7, 2, -256));
    emit(i_type(AND, 8, 1, 12'h0f0));
    emit(i_type(SLL, 9, 1, 40));
    emit(i_type(SRL_SRA, 10, 1, 60));
    emit(i_type(SRL_SRA, 11, 1, 12'h400 | 33));  // srai
    emit(i_type(SLT, 12, 2, -1));
    execute_and_check("imm_arith");
  endtask

  task automatic reg_arith();
    prog_len = 0;
    emit(u_type(1, 20'h80000));      // Sign bit set
    emit(i_type(ADD_SUB, 2, 0, -3));
    emit(i_type(ADD_SUB, 3, 0, 7));
    emit(i_type(ADD_SUB, 14, 0, 65));
    emit(r_type(ADD_SUB, 0, 4, 1, 2));
    emit(r_type(ADD_SUB, 1, 5, 3, 1));
    emit(r_type(SLL, 0, 6, 2, 3));
    emit(r_type(SLT, 0, 7, 1, 3));
    emit(r_type(SLTU, 0, 8, 1, 3));
    emit(r_type(XOR, 0, 9, 1, 2));
    emit(r_type(SRL_SRA, 0, 10, 1, 3));
    emit(r_type(SRL_SRA, 1, 11, 1, 3));
    emit(r_type(OR, 0, 12, 2, 3));
    emit(r_type(AND, 0, 13, 1, 2));
    emit(r_type(SLL, 0, 15, 3, 14));  // Amount wraps at 64
    execute_and_check("reg_arith");
  endtask

  task automatic zero_reg();
    prog_len = 0;
    emit(i_type(ADD_SUB, 1, 0, 9));
    emit(i_type(ADD_SUB, 0, 1, 5));
    emit(r_type(ADD_SUB, 0, 0, 1, 1));
    emit(u_type(0, 20'h12345));
    emit(r_type(ADD_SUB, 0, 2, 0, 1));
    emit(i_type(OR, 3, 0, 0));
    execute_and_check("zero_reg");
  endtask

  task automatic lui_jal();
    prog_len = 0;
    emit(u_type(1, 20'hfffff));
    emit(u_type(2, 20'h7ffff));
    emit(j_type(3, 8));
    emit(i_type(ADD_SUB, 4, 0, 77));  // Skipped
    emit(i_type(ADD_SUB, 5, 0, 1));
    emit(j_type(6, 12));
    emit(i_type(ADD_SUB, 7, 0, 1));   // Skipped
    emit(i_type(ADD_SUB, 8, 0, 1));   // Skipped
    emit(i_type(ADD_SUB, 9, 3, 0));
    execute_and_check("lui_jal");
  endtask

  task automatic random_seq();
    int op;
    prog_len = 0;
    for (int n = 0; n < 40; n++) begin
      op = int'($urandom % 5);
      case (op)
        0: emit(i_type(ADD_SUB, $urandom % 32, $urandom % 32, $urandom % 4096));
        1: emit(r_type(ADD_SUB, 0, $urandom % 32, $urandom % 32, $urandom % 32));
        2: emit(r_type(ADD_SUB, 1, $urandom % 32, $urandom % 32, $urandom % 32));
        3: emit(r_type(XOR, 0, $urandom % 32, $urandom % 32, $urandom % 32));
        default: emit(u_type($urandom % 32, $urandom % 1048576));
      endcase
    end
    execute_and_check("random_seq");
  endtask

  initial begin
    test_rst     = 1'b0;
    prog_len     = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'h6deb6f39));
    for (int i = 0; i < 20 && por_rst !== 1'b0; i++) @(negedge clk);
    if (por_rst !== 1'b0) begin
      $display("Power-on reset was never released");
      tests_failed++;
    end
    reset_state();
    imm_arith();
    reg_arith();
    zero_reg();
    lui_jal();
    random_seq();
    $display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 50,
  parameter int RESET_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== rvcpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module rvcpu
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int              XLEN     = 64,
  parameter logic [XLEN-1:0] RESET_PC = 64'h8000_0000
) (
  input  wire              clk,
  input  wire              rst,
  output logic [XLEN-1:0]  inst_addr,
  output logic             inst_ena,
  input  inst_t            inst,
  output logic [XLEN-1:0]  regs_o [NUM_REGS]
);

  logic [XLEN-1:0] pc;
  inst_t           inst_id;
  ctrl_t           ctrl;
  reg_addr_t       r_addr1;
  reg_addr_t       r_addr2;
  logic            r_ena1;
  logic            r_ena2;
  logic [XLEN-1:0] r_data1;
  logic [XLEN-1:0] r_data2;
  reg_addr_t       w_addr;
  logic [XLEN-1:0] w_data;
  logic            w_ena;

  if_stage #(.XLEN(XLEN), .RESET_PC(RESET_PC)) i_if_stage (
    .clk, .rst, .ctrl, .inst,
    .pc, .inst_addr, .inst_ena,
    .inst_out (inst_id)
  );

  id_stage i_id_stage (
    .inst (inst_id),
    .r_addr1, .r_addr2, .r_ena1, .r_ena2, .ctrl
  );

  regfile #(.XLEN(XLEN)) i_regfile (
    .clk, .rst,
    .w_addr, .w_data, .w_ena,
    .r_addr1, .r_ena1, .r_addr2, .r_ena2,
    .r_data1, .r_data2,
    .regs_o
  );

  exe_stage #(.XLEN(XLEN)) i_exe_stage (
    .pc, .ctrl, .r_data1, .r_data2,
    .w_addr, .w_data, .w_ena
  );

endmodule

`default_nettype wire

// ==== exe_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module exe_stage
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int XLEN = 64
) (
  input  wire  [XLEN-1:0]  pc,
  input  ctrl_t            ctrl,
  input  wire  [XLEN-1:0]  r_data1,
  input  wire  [XLEN-1:0]  r_data2,
  output reg_addr_t        w_addr,
  output logic [XLEN-1:0]  w_data,
  output logic             w_ena
);

  localparam int SHAMT_W = $clog2(XLEN);

  logic [XLEN-1:0]    op_a;
  logic [XLEN-1:0]    op_b;
  logic [SHAMT_W-1:0] shamt;
  logic               lt_s;
  logic               lt_u;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Operand select
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign op_a  = ctrl.use_pc  ? pc : r_data1;
  assign op_b  = ctrl.use_imm ? ctrl.imm[XLEN-1:0] : r_data2;
  assign shamt = op_b[SHAMT_W-1:0];

  assign lt_s = $signed(op_a) < $signed(op_b);
  assign lt_u = op_a < op_b;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    unique case (ctrl.alu_op)
      ALU_ADD:    w_data = op_a + op_b;
      ALU_SUB:    w_data = op_a - op_b;
      ALU_SLL:    w_data = op_a << shamt;
      ALU_SLT:    w_data = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   w_data = {{(XLEN-1){1'b0}}, lt_u};
      ALU_XOR:    w_data = op_a ^ op_b;
      ALU_SRL:    w_data = op_a >> shamt;
      ALU_SRA:    w_data = $signed(op_a) >>> shamt;
      ALU_OR:     w_data = op_a | op_b;
      ALU_AND:    w_data = op_a & op_b;
      ALU_PASS_B: w_data = op_b;
      default:    w_data = '0;
    endcase
  end

  assign w_addr = ctrl.rd;
  assign w_ena  = ctrl.rd_wen;

endmodule

`default_nettype wire

// ==== regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module regfile
  import isa_pkg::*;
#(
  parameter int XLEN = 64
) (
  input  wire              clk,
  input  wire              rst,
  input  reg_addr_t        w_addr,
  input  wire  [XLEN-1:0]  w_data,
  input  wire              w_ena,
  input  reg_addr_t        r_addr1,
  input  wire              r_ena1,
  input  reg_addr_t        r_addr2,
  input  wire              r_ena2,
  output logic [XLEN-1:0]  r_data1,
  output logic [XLEN-1:0]  r_data2,
  output logic [XLEN-1:0]  regs_o [NUM_REGS]  // difftest
);

  logic [XLEN-1:0] regs [NUM_REGS];
  logic            wr;

  assign wr = w_ena && (w_addr != '0);  // x0 stays zero

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr) begin
      regs[w_addr] <= w_data;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Read ports and difftest view
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign r_data1 = (rst || !r_ena1) ? '0 : regs[r_addr1];
  assign r_data2 = (rst || !r_ena2) ? '0 : regs[r_addr2];

  // Current cycle's write already shows
  always_comb begin
    for (int i = 0; i < NUM_REGS; i++) begin
      regs_o[i] = (wr && w_addr == reg_addr_t'(i)) ? w_data : regs[i];
    end
  end

endmodule

`default_nettype wire

// ==== id_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module id_stage
  import isa_pkg::*;
  import core_pkg::*;
(
  input  inst_t      inst,
  output reg_addr_t  r_addr1,
  output reg_addr_t  r_addr2,
  output logic       r_ena1,
  output logic       r_ena2,
  output ctrl_t      ctrl
);

  opcode_e     opcode;
  funct3_e     funct3;
  logic        funct7_b5;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic [63:0] imm_j;
  alu_op_e     alu_op_f3;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction fields
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign opcode    = opcode_e'(inst[6:0]);
  assign funct3    = funct3_e'(inst[14:12]);
  assign funct7_b5 = inst[30];

  assign r_addr1 = inst[19:15];
  assign r_addr2 = inst[24:20];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // Shared funct3 map for OP and OP-IMM
  always_comb begin
    unique case (funct3)
      ADD_SUB: alu_op_f3 = ALU_ADD;
      SLL:     alu_op_f3 = ALU_SLL;
      SLT:     alu_op_f3 = ALU_SLT;
      SLTU:    alu_op_f3 = ALU_SLTU;
      XOR:     alu_op_f3 = ALU_XOR;
      SRL_SRA: alu_op_f3 = funct7_b5 ? ALU_SRA : ALU_SRL;
      OR:      alu_op_f3 = ALU_OR;
      AND:     alu_op_f3 = ALU_AND;
      default: alu_op_f3 = ALU_ADD;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    // Defaults give a no-op
    r_ena1           = 1'b0;
    r_ena2           = 1'b0;
    ctrl.alu_op      = ALU_ADD;
    ctrl.use_imm     = 1'b0;
    ctrl.use_pc      = 1'b0;
    ctrl.imm         = '0;
    ctrl.rd          = inst[11:7];
    ctrl.rd_wen      = 1'b0;
    ctrl.jump        = 1'b0;
    ctrl.jump_offset = '0;

    case (opcode)
      OP_IMM: begin
        r_ena1       = 1'b1;
        ctrl.alu_op  = alu_op_f3;  // funct3 000 is always addi here
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_i;      // shamt sits in the low bits
        ctrl.rd_wen  = 1'b1;
      end
      OP: begin
        r_ena1      = 1'b1;
        r_ena2      = 1'b1;
        ctrl.rd_wen = 1'b1;
        if (funct3 == ADD_SUB && funct7_b5) begin
          ctrl.alu_op = ALU_SUB;
        end else begin
          ctrl.alu_op = alu_op_f3;
        end
      end
      LUI: begin
        ctrl.alu_op  = ALU_PASS_B;
        ctrl.use_imm = 1'b1;
        ctrl.imm     = imm_u;
        ctrl.rd_wen  = 1'b1;
      end
      JAL: begin
        // Link value is pc + 4 through the ALU
        ctrl.alu_op      = ALU_ADD;
        ctrl.use_pc      = 1'b1;
        ctrl.use_imm     = 1'b1;
        ctrl.imm         = 64'd4;
        ctrl.rd_wen      = 1'b1;
        ctrl.jump        = 1'b1;
        ctrl.jump_offset = imm_j;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== if_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module if_stage
  import isa_pkg::*;
  import core_pkg::*;
#(
  parameter int              XLEN     = 64,
  parameter logic [XLEN-1:0] RESET_PC = 64'h8000_0000
) (
  input  wire              clk,
  input  wire              rst,
  input  ctrl_t            ctrl,
  input  inst_t            inst,
  output logic [XLEN-1:0]  pc,
  output logic [XLEN-1:0]  inst_addr,
  output logic             inst_ena,
  output inst_t            inst_out
);

  logic [XLEN-1:0] pc_next;

  // Jal redirects and everything else falls through
  assign pc_next = ctrl.jump ? pc + ctrl.jump_offset[XLEN-1:0] : pc + XLEN'(4);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign inst_addr = pc;
  assign inst_ena  = ~rst;

  // Nothing executes while fetch is off
  assign inst_out = inst_ena ? inst : NOP;

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
`default_nettype none

package core_pkg;

  import isa_pkg::*;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Decoded control from id_stage to the datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    alu_op_e     alu_op;
    logic        use_imm;      // Operand B from imm
    logic        use_pc;       // Operand A from pc
    logic [63:0] imm;          // Sign-extended
    reg_addr_t   rd;
    logic        rd_wen;
    logic        jump;
    logic [63:0] jump_offset;  // Added to pc on jal
  } ctrl_t;

endpackage

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int INST_W     = 32;
  localparam int OPCODE_W   = 7;
  localparam int FUNCT3_W   = 3;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [INST_W-1:0]     inst_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Major opcodes of the implemented subset
  typedef enum logic [OPCODE_W-1:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [FUNCT3_W-1:0] {
    ADD_SUB = 3'b000,  // funct7[5] picks sub for OP
    SLL     = 3'b001,
    SLT     = 3'b010,
    SLTU    = 3'b011,
    XOR     = 3'b100,
    SRL_SRA = 3'b101,  // funct7[5] picks sra
    OR      = 3'b110,
    AND     = 3'b111
  } funct3_e;

  // addi x0, x0, 0
  localparam inst_t NOP = 32'h0000_0013;

endpackage

`default_nettype wire
